// File: all.f
+incdir+source
source/tile_pkg.sv
source/wb_if.sv
source/axi_if.sv
source/dbg_cmd_ctrl.sv
source/wb2axi_bridge.sv
source/axi_ram.sv
source/host_tx_fifo.sv
source/tile_mem_top.sv
verif/tile_mem_sva.sv
verif/tb_tile_mem.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_tile_mem -o sim_tb &&
./obj_dir/sim_tb || exit 1

// File: verif/tb_tile_mem.sv
// Directed regression for the tile memory path, run as the simulation top level
`timescale 1ns/1ps
`default_nettype none

`include "tile_macros.svh"

module tb_tile_mem;

   // 200 random commands of at most about 30 cycles each, plus the directed tests
   localparam int TIMEOUT_CYCLES = 20000;
   localparam int RANDOM_OPS     = 200;

   logic                         clk;
   logic                         rst_i;
   logic                         in_valid_i;
   logic [`TILE_HOST_WIDTH-1:0]  in_data_i;
   logic                         in_ready_o;
   logic                         out_valid_o;
   logic [`TILE_HOST_WIDTH-1:0]  out_data_o;
   logic                         out_ready_i;

   // Expected memory contents, and words whose every byte is known
   tile_pkg::data_word_t  ref_mem [`TILE_MEM_WORDS];
   bit                    known [`TILE_MEM_WORDS];
   int                    cycle_count = 0;

   tile_mem_top i_tile_mem_top (
      .clk         (clk),
      .rst_i       (rst_i),
      .in_valid_i  (in_valid_i),
      .in_data_i   (in_data_i),
      .in_ready_o  (in_ready_o),
      .out_valid_o (out_valid_o),
      .out_data_o  (out_data_o),
      .out_ready_i (out_ready_i)
   );

   always #2 clk = ~clk;

   task automatic fail_now(input string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1, "Run stopped at the first failure");
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         fail_now($sformatf("Timeout: the run did not finish within %0d cycles", cycle_count));
      end
   end

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic send_word(input logic [`TILE_HOST_WIDTH-1:0] w);
      in_valid_i = 1'b1;
      in_data_i  = w;
      while (!in_ready_o) begin
         next_cycle();
      end
      next_cycle();
      in_valid_i = 1'b0;
   endtask

   // Optionally stalls the output for a few cycles before taking the word
   task automatic recv_word(input int stall, output logic [`TILE_HOST_WIDTH-1:0] w);
      repeat (stall) begin
         next_cycle();
      end
      out_ready_i = 1'b1;
      while (!out_valid_o) begin
         next_cycle();
      end
      w = out_data_o;
      next_cycle();
      out_ready_i = 1'b0;
   endtask

   function automatic logic [`TILE_HOST_WIDTH-1:0] make_header(input logic [1:0] op,
                                                               input logic [3:0] sel);
      tile_pkg::host_word_u hw;
      hw.raw          = '0;
      hw.hdr.opcode   = tile_pkg::host_op_e'(op);
      hw.hdr.byte_sel = sel;
      return hw.raw;
   endfunction

   function automatic logic [`TILE_ADDR_WIDTH-1:0] byte_addr(input int idx,
                                                             input logic [1:0] off);
      logic [31:0] word;
      word = idx;
      return {word[`TILE_ADDR_WIDTH-3:0], off};
   endfunction

   task automatic check_status(input tile_pkg::resp_status_e got,
                               input tile_pkg::resp_status_e exp, input string what);
      if (got !== exp) begin
         fail_now($sformatf("Mismatch at %0t: %s status 0x%04h, expected 0x%04h",
                            $time, what, got, exp));
      end
   endtask

   task automatic check_data(input tile_pkg::data_word_t got,
                             input tile_pkg::data_word_t exp, input string what);
      if (got !== exp) begin
         fail_now($sformatf("Mismatch at %0t: %s data 0x%08h, expected 0x%08h",
                            $time, what, got, exp));
      end
   endtask

   task automatic write_cmd(input logic [`TILE_ADDR_WIDTH-1:0] addr,
                            input tile_pkg::data_word_t data, input logic [3:0] sel);
      int                           idx;
      tile_pkg::resp_status_e       exp;
      logic [`TILE_HOST_WIDTH-1:0]  st;
      idx = int'(addr[`TILE_ADDR_WIDTH-1:2]);
      send_word(make_header(tile_pkg::OP_WRITE, sel));
      send_word(`TILE_HOST_WIDTH'(addr >> 16));
      send_word(addr[15:0]);
      send_word(data[31:16]);
      send_word(data[15:0]);
      recv_word(0, st);
      exp = tile_pkg::ST_BUS_ERR;
      if (idx < `TILE_MEM_WORDS) begin
         exp = tile_pkg::ST_OK;
         for (int b = 0; b < 4; b++) begin
            if (sel[b]) ref_mem[idx][8*b +: 8] = data[8*b +: 8];
         end
         if (sel == 4'hf) known[idx] = 1'b1;
      end
      check_status(tile_pkg::resp_status_e'(st), exp, "write");
   endtask

   task automatic send_read(input logic [`TILE_ADDR_WIDTH-1:0] addr);
      send_word(make_header(tile_pkg::OP_READ, 4'h0));
      send_word(`TILE_HOST_WIDTH'(addr >> 16));
      send_word(addr[15:0]);
   endtask

   task automatic collect_read(input logic [`TILE_ADDR_WIDTH-1:0] addr, input int stall);
      int                           idx;
      logic [`TILE_HOST_WIDTH-1:0]  st;
      logic [`TILE_HOST_WIDTH-1:0]  hi;
      logic [`TILE_HOST_WIDTH-1:0]  lo;
      idx = int'(addr[`TILE_ADDR_WIDTH-1:2]);
      recv_word(stall, st);
      recv_word(stall, hi);
      recv_word(stall, lo);
      if (idx < `TILE_MEM_WORDS) begin
         check_status(tile_pkg::resp_status_e'(st), tile_pkg::ST_OK, "read");
         check_data({hi, lo}, ref_mem[idx], "read");
      end else begin
         check_status(tile_pkg::resp_status_e'(st), tile_pkg::ST_BUS_ERR, "read");
         check_data({hi, lo}, '0, "read");
      end
   endtask

   task automatic read_cmd(input logic [`TILE_ADDR_WIDTH-1:0] addr, input int stall);
      send_read(addr);
      collect_read(addr, stall);
   endtask

   task automatic test_write_read();
      write_cmd(byte_addr(3, 2'b00), 32'hdead_beef, 4'hf);
      read_cmd(byte_addr(3, 2'b00), 0);
      write_cmd(byte_addr(`TILE_MEM_WORDS - 1, 2'b11), 32'h1357_9bdf, 4'hf);
      read_cmd(byte_addr(`TILE_MEM_WORDS - 1, 2'b01), 1);
   endtask

   task automatic test_partial_write();
      write_cmd(byte_addr(3, 2'b00), 32'h1122_3344, 4'b0101);
      read_cmd(byte_addr(3, 2'b00), 0);
      write_cmd(byte_addr(3, 2'b10), 32'ha5a5_a5a5, 4'b1000);
      read_cmd(byte_addr(3, 2'b00), 0);
   endtask

   task automatic test_out_of_range();
      write_cmd(byte_addr(5, 2'b00), 32'h5a5a_0505, 4'hf);
      write_cmd(byte_addr(`TILE_MEM_WORDS + 5, 2'b00), 32'hffff_ffff, 4'hf);
      read_cmd(byte_addr(`TILE_MEM_WORDS + 5, 2'b00), 0);
      read_cmd(byte_addr(5, 2'b00), 0);
   endtask

   task automatic test_illegal_op();
      logic [`TILE_HOST_WIDTH-1:0] st;
      send_word(make_header(2'd0, 4'hf));
      recv_word(0, st);
      check_status(tile_pkg::resp_status_e'(st), tile_pkg::ST_BAD_OP, "opcode 0");
      send_word(make_header(2'd3, 4'hf));
      recv_word(0, st);
      check_status(tile_pkg::resp_status_e'(st), tile_pkg::ST_BAD_OP, "opcode 3");
      read_cmd(byte_addr(5, 2'b00), 0);
      read_cmd(byte_addr(3, 2'b00), 0);
   endtask

   // Nine response words overflow the FIFO, so the third read stalls the controller
   task automatic test_backpressure();
      for (int i = 0; i < 3; i++) begin
         write_cmd(byte_addr(10 + i, 2'b00), $urandom, 4'hf);
      end
      for (int i = 0; i < 3; i++) begin
         send_read(byte_addr(10 + i, 2'b00));
      end
      in_valid_i = 1'b1;
      in_data_i  = make_header(tile_pkg::OP_READ, 4'h0);
      repeat (16) begin
         if (in_ready_o) fail_now("Host link accepted a word while the response FIFO was full");
         next_cycle();
      end
      in_valid_i = 1'b0;
      for (int i = 0; i < 3; i++) begin
         collect_read(byte_addr(10 + i, 2'b00), 0);
      end
   endtask

   task automatic test_random();
      int                           idx;
      logic [`TILE_ADDR_WIDTH-1:0]  addr;
      tile_pkg::data_word_t         data;
      for (int n = 0; n < RANDOM_OPS; n++) begin
         // Pool of 40 words spread over the whole memory
         idx  = int'($urandom % 40) * 25;
         addr = byte_addr(idx, 2'($urandom));
         data = $urandom;
         if (!known[idx]) begin
            write_cmd(addr, data, 4'hf);
         end else if ($urandom % 2 == 0) begin
            write_cmd(addr, data, 4'($urandom));
         end else begin
            read_cmd(addr, int'($urandom % 3));
         end
      end
   endtask

   initial begin
      void'($urandom(47992));
      clk         = 1'b0;
      rst_i       = 1'b1;
      in_valid_i  = 1'b0;
      in_data_i   = '0;
      out_ready_i = 1'b0;
      repeat (5) @(posedge clk);
      #1;
      rst_i = 1'b0;
      if (!in_ready_o || out_valid_o) fail_now("Host link not idle after reset");
      test_write_read();
      test_partial_write();
      test_out_of_range();
      test_illegal_op();
      test_backpressure();
      test_random();
      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/tile_mem_sva.sv
// Wishbone and host output protocol assertions, bound into the tile memory top level
`timescale 1ns/1ps
`default_nettype none

`include "tile_macros.svh"

module tile_mem_sva (
   input wire                          clk_i,
   input wire                          rst_i,
   input wire                          cyc_i,
   input wire                          stb_i,
   input wire                          ack_i,
   input wire                          err_i,
   input wire                          out_valid_i,
   input wire                          out_ready_i,
   input wire [`TILE_HOST_WIDTH-1:0]   out_data_i
);

   // Strobe and cycle stay up together until the slave terminates the cycle
   cycle_held: assert property (@(posedge clk_i) disable iff (rst_i)
      stb_i && !(ack_i || err_i) |=> stb_i && cyc_i)
      else $error("Wishbone cycle dropped before ack or err");

   // Termination lasts one cycle and closes the bus cycle
   cycle_ended: assert property (@(posedge clk_i) disable iff (rst_i)
      (ack_i || err_i) |=> !cyc_i && !stb_i && !ack_i && !err_i)
      else $error("Wishbone cycle not closed after ack or err");

   // Only an open cycle is answered, and never with both ack and err
   ack_err_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
      (ack_i || err_i) |-> cyc_i && stb_i && !(ack_i && err_i))
      else $error("Wishbone ack or err outside a cycle, or both high together");

   // Stalled output word must hold until taken
   out_data_held: assert property (@(posedge clk_i) disable iff (rst_i)
      out_valid_i && !out_ready_i |=> $stable(out_data_i))
      else $error("Host output data changed while stalled");

endmodule

bind tile_mem_top tile_mem_sva u_sva (
   .clk_i       (clk),
   .rst_i       (rst_i),
   .cyc_i       (wb_bus.cyc),
   .stb_i       (wb_bus.stb),
   .ack_i       (wb_bus.ack),
   .err_i       (wb_bus.err),
   .out_valid_i (out_valid_o),
   .out_ready_i (out_ready_i),
   .out_data_i  (out_data_o)
);

`default_nettype wire

// File: source/tile_mem_top.sv
// Tile memory path top level, host link in and out as plain ports
`timescale 1ns/1ps
`default_nettype none

`include "tile_macros.svh"

module tile_mem_top (
   input  wire                          clk,
   input  wire                          rst_i,
   input  wire                          in_valid_i,
   input  wire [`TILE_HOST_WIDTH-1:0]   in_data_i,
   output logic                         in_ready_o,
   output logic                         out_valid_o,
   output logic [`TILE_HOST_WIDTH-1:0]  out_data_o,
   input  wire                          out_ready_i
);

   wb_if  wb_bus ();
   axi_if axi_bus ();

   // Controller to response FIFO
   logic                         tx_push;
   logic [`TILE_HOST_WIDTH-1:0]  tx_data;
   logic                         tx_full;

   dbg_cmd_ctrl u_cmd_ctrl (
      .clk        (clk),
      .rst_i      (rst_i),
      .in_valid_i (in_valid_i),
      .in_data_i  (in_data_i),
      .in_ready_o (in_ready_o),
      .wb         (wb_bus.master),
      .tx_push_o  (tx_push),
      .tx_data_o  (tx_data),
      .tx_full_i  (tx_full)
   );

   wb2axi_bridge u_wb2axi (
      .clk   (clk),
      .rst_i (rst_i),
      .wb    (wb_bus.slave),
      .axi   (axi_bus.master)
   );

   axi_ram #(.DEPTH(`TILE_MEM_WORDS)) u_ram (
      .clk   (clk),
      .rst_i (rst_i),
      .axi   (axi_bus.slave)
   );

   host_tx_fifo #(.DEPTH(`TILE_RESP_DEPTH)) u_tx_fifo (
      .clk         (clk),
      .rst_i       (rst_i),
      .push_i      (tx_push),
      .data_i      (tx_data),
      .full_o      (tx_full),
      .out_valid_o (out_valid_o),
      .out_data_o  (out_data_o),
      .out_ready_i (out_ready_i)
   );

endmodule

`default_nettype wire

// File: source/host_tx_fifo.sv
// Response word FIFO feeding the host link, valid/ready on the output side
`timescale 1ns/1ps
`default_nettype none

`include "tile_macros.svh"

module host_tx_fifo #(
   parameter int DEPTH = 8
) (
   input  wire                          clk,
   input  wire                          rst_i,
   input  wire                          push_i,
   input  wire [`TILE_HOST_WIDTH-1:0]   data_i,
   output logic                         full_o,
   output logic                         out_valid_o,
   output logic [`TILE_HOST_WIDTH-1:0]  out_data_o,
   input  wire                          out_ready_i
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [`TILE_HOST_WIDTH-1:0]  mem_q [DEPTH];
   logic [PTR_W-1:0]             wr_ptr_q;
   logic [PTR_W-1:0]             rd_ptr_q;
   logic [CNT_W-1:0]             count_q;
   logic                         do_push;
   logic                         do_pop;

   assign full_o      = (count_q == CNT_W'(DEPTH));
   assign out_valid_o = (count_q != '0);
   assign out_data_o  = mem_q[rd_ptr_q];
   assign do_push     = push_i && !full_o;
   assign do_pop      = out_valid_o && out_ready_i;

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem_q[wr_ptr_q] <= data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         // Pointers wrap at DEPTH, which need not be a power of two
         if (do_push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (do_pop) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: source/axi_ram.sv
// AXI word memory with byte strobes, standing in for the DRAM controller
`timescale 1ns/1ps
`default_nettype none

`include "tile_macros.svh"

module axi_ram #(
   parameter int DEPTH = 1024
) (
   input  wire    clk,
   input  wire    rst_i,
   axi_if.slave   axi
);

   localparam int IDX_W = $clog2(DEPTH);

   tile_pkg::data_word_t           mem [DEPTH];
   logic [`TILE_ADDR_WIDTH-3:0]    aw_idx;
   logic [`TILE_ADDR_WIDTH-3:0]    ar_idx;
   logic                           aw_in_range;
   logic                           ar_in_range;
   logic                           wr_accept;
   logic                           rd_accept;
   logic                           b_valid_q;
   logic                           r_valid_q;
   tile_pkg::axi_resp_e            b_resp_q;
   tile_pkg::axi_resp_e            r_resp_q;
   tile_pkg::data_word_t           r_data_q;

   // Word index, byte offset bits are dropped
   assign aw_idx      = axi.aw_addr[`TILE_ADDR_WIDTH-1:2];
   assign ar_idx      = axi.ar_addr[`TILE_ADDR_WIDTH-1:2];
   assign aw_in_range = (aw_idx < DEPTH);
   assign ar_in_range = (ar_idx < DEPTH);

   // Address and data are taken together, one write at a time
   assign wr_accept    = axi.aw_valid && axi.w_valid && !b_valid_q;
   assign axi.aw_ready = wr_accept;
   assign axi.w_ready  = wr_accept;
   assign axi.b_valid  = b_valid_q;
   assign axi.b_resp   = b_resp_q;

   assign rd_accept    = axi.ar_valid && !r_valid_q;
   assign axi.ar_ready = !r_valid_q;
   assign axi.r_valid  = r_valid_q;
   assign axi.r_resp   = r_resp_q;
   assign axi.r_data   = r_data_q;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         b_valid_q <= 1'b0;
         r_valid_q <= 1'b0;
      end else begin
         if (wr_accept) b_valid_q <= 1'b1;
         else if (axi.b_ready) b_valid_q <= 1'b0;
         if (rd_accept) r_valid_q <= 1'b1;
         else if (axi.r_ready) r_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_accept) begin
         if (aw_in_range) begin
            b_resp_q <= tile_pkg::AXI_OKAY;
            for (int b = 0; b < `TILE_DATA_WIDTH/8; b++) begin
               if (axi.w_strb[b]) mem[aw_idx[IDX_W-1:0]][8*b +: 8] <= axi.w_data[8*b +: 8];
            end
         end else begin
            b_resp_q <= tile_pkg::AXI_SLVERR;
         end
      end
      if (rd_accept) begin
         if (ar_in_range) begin
            r_resp_q <= tile_pkg::AXI_OKAY;
            r_data_q <= mem[ar_idx[IDX_W-1:0]];
         end else begin
            r_resp_q <= tile_pkg::AXI_SLVERR;
            r_data_q <= '0;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/wb2axi_bridge.sv
// Turns each Wishbone cycle into one single-beat AXI write or read
`timescale 1ns/1ps
`default_nettype none

module wb2axi_bridge (
   input  wire    clk,
   input  wire    rst_i,
   wb_if.slave    wb,
   axi_if.master  axi
);

   localparam logic [1:0] B_IDLE   = 2'd0;
   localparam logic [1:0] B_ACTIVE = 2'd1;
   localparam logic [1:0] B_DONE   = 2'd2;

   logic [1:0]            state_q;
   logic                  aw_valid_q;
   logic                  w_valid_q;
   logic                  ar_valid_q;
   logic                  ack_q;
   logic                  err_q;
   logic                  resp_ok;
   logic                  resp_fire;
   tile_pkg::data_word_t  rdata_q;

   // Address and data are held stable by the master during the cycle
   assign axi.aw_valid = aw_valid_q;
   assign axi.aw_addr  = wb.adr;
   assign axi.w_valid  = w_valid_q;
   assign axi.w_data   = wb.dat_w;
   assign axi.w_strb   = wb.sel;
   assign axi.b_ready  = (state_q == B_ACTIVE) && wb.we;
   assign axi.ar_valid = ar_valid_q;
   assign axi.ar_addr  = wb.adr;
   assign axi.r_ready  = (state_q == B_ACTIVE) && !wb.we;

   assign resp_fire = (axi.b_valid && axi.b_ready) || (axi.r_valid && axi.r_ready);
   assign resp_ok   = wb.we ? (axi.b_resp == tile_pkg::AXI_OKAY)
                            : (axi.r_resp == tile_pkg::AXI_OKAY);

   assign wb.ack   = ack_q;
   assign wb.err   = err_q;
   assign wb.dat_r = rdata_q;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q    <= B_IDLE;
         aw_valid_q <= 1'b0;
         w_valid_q  <= 1'b0;
         ar_valid_q <= 1'b0;
         ack_q      <= 1'b0;
         err_q      <= 1'b0;
      end else begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
         case (state_q)
            B_IDLE: begin
               if (wb.cyc && wb.stb) begin
                  aw_valid_q <= wb.we;
                  w_valid_q  <= wb.we;
                  ar_valid_q <= !wb.we;
                  state_q    <= B_ACTIVE;
               end
            end
            B_ACTIVE: begin
               // aw and w may be taken in different cycles
               if (aw_valid_q && axi.aw_ready) aw_valid_q <= 1'b0;
               if (w_valid_q && axi.w_ready) w_valid_q <= 1'b0;
               if (ar_valid_q && axi.ar_ready) ar_valid_q <= 1'b0;
               if (resp_fire) begin
                  ack_q   <= resp_ok;
                  err_q   <= !resp_ok;
                  state_q <= B_DONE;
               end
            end
            default: state_q <= B_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (axi.r_valid && axi.r_ready) begin
         rdata_q <= axi.r_data;
      end
   end

endmodule

`default_nettype wire

// File: source/dbg_cmd_ctrl.sv
// Host command FSM: parses host words, runs one Wishbone cycle and pushes response words
`timescale 1ns/1ps
`default_nettype none

`include "tile_macros.svh"

module dbg_cmd_ctrl (
   input  wire                          clk,
   input  wire                          rst_i,
   input  wire                          in_valid_i,
   input  wire [`TILE_HOST_WIDTH-1:0]   in_data_i,
   output logic                         in_ready_o,
   wb_if.master                         wb,
   output logic                         tx_push_o,
   output logic [`TILE_HOST_WIDTH-1:0]  tx_data_o,
   input  wire                          tx_full_i
);

   localparam logic [2:0] S_HDR     = 3'd0;
   localparam logic [2:0] S_ADDR_HI = 3'd1;
   localparam logic [2:0] S_ADDR_LO = 3'd2;
   localparam logic [2:0] S_DATA_HI = 3'd3;
   localparam logic [2:0] S_DATA_LO = 3'd4;
   localparam logic [2:0] S_BUS     = 3'd5;
   localparam logic [2:0] S_RESP    = 3'd6;

   logic [2:0]                     state_q;
   logic [1:0]                     resp_cnt_q;
   logic [1:0]                     resp_last_q;
   logic                           in_fire;
   logic                           hdr_legal;
   logic                           bus_done;
   tile_pkg::host_word_u           host_w;
   tile_pkg::resp_status_e         status_q;
   logic                           we_q;
   logic [`TILE_DATA_WIDTH/8-1:0]  sel_q;
   logic [`TILE_ADDR_WIDTH-1:0]    addr_q;
   tile_pkg::data_word_t           wdata_q;
   tile_pkg::data_word_t           rdata_q;

   // Same input word seen as raw bits and as a header
   always_comb begin
      host_w.raw = in_data_i;
   end

   assign hdr_legal = (host_w.hdr.opcode == tile_pkg::OP_READ) ||
                      (host_w.hdr.opcode == tile_pkg::OP_WRITE);

   assign in_ready_o = state_q inside {S_HDR, S_ADDR_HI, S_ADDR_LO, S_DATA_HI, S_DATA_LO};
   assign in_fire    = in_valid_i && in_ready_o;
   assign bus_done   = (state_q == S_BUS) && (wb.ack || wb.err);
   assign tx_push_o  = (state_q == S_RESP) && !tx_full_i;

   // Cycle stays up for the whole bus state, fields come from registers
   assign wb.cyc   = (state_q == S_BUS);
   assign wb.stb   = (state_q == S_BUS);
   assign wb.we    = we_q;
   assign wb.adr   = addr_q;
   assign wb.dat_w = wdata_q;
   assign wb.sel   = we_q ? sel_q : '1;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q    <= S_HDR;
         resp_cnt_q <= 2'd0;
      end else begin
         case (state_q)
            S_HDR: begin
               if (in_fire) begin
                  state_q <= hdr_legal ? S_ADDR_HI : S_RESP;
               end
            end
            S_ADDR_HI: if (in_fire) state_q <= S_ADDR_LO;
            S_ADDR_LO: if (in_fire) state_q <= we_q ? S_DATA_HI : S_BUS;
            S_DATA_HI: if (in_fire) state_q <= S_DATA_LO;
            S_DATA_LO: if (in_fire) state_q <= S_BUS;
            S_BUS: if (bus_done) state_q <= S_RESP;
            default: begin
               if (tx_push_o) begin
                  if (resp_cnt_q == resp_last_q) begin
                     resp_cnt_q <= 2'd0;
                     state_q    <= S_HDR;
                  end else begin
                     resp_cnt_q <= resp_cnt_q + 2'd1;
                  end
               end
            end
         endcase
      end
   end

   // Command fields and the result of the bus cycle
   always_ff @(posedge clk) begin
      if (in_fire) begin
         case (state_q)
            S_HDR: begin
               we_q        <= (host_w.hdr.opcode == tile_pkg::OP_WRITE);
               sel_q       <= host_w.hdr.byte_sel;
               status_q    <= tile_pkg::ST_BAD_OP;
               resp_last_q <= 2'd0;
            end
            S_ADDR_HI: addr_q[`TILE_ADDR_WIDTH-1:16] <= in_data_i[`TILE_ADDR_WIDTH-17:0];
            S_ADDR_LO: addr_q[15:0] <= in_data_i;
            S_DATA_HI: wdata_q[`TILE_DATA_WIDTH-1:`TILE_HOST_WIDTH] <= in_data_i;
            S_DATA_LO: wdata_q[`TILE_HOST_WIDTH-1:0] <= in_data_i;
            default: ;
         endcase
      end
      if (bus_done) begin
         if (wb.err) begin
            status_q <= tile_pkg::ST_BUS_ERR;
            rdata_q  <= '0;
         end else begin
            status_q <= tile_pkg::ST_OK;
            rdata_q  <= wb.dat_r;
         end
         // Reads answer with status plus two data halves
         resp_last_q <= we_q ? 2'd0 : 2'd2;
      end
   end

   always_comb begin
      case (resp_cnt_q)
         2'd0:    tx_data_o = status_q;
         2'd1:    tx_data_o = rdata_q[`TILE_DATA_WIDTH-1:`TILE_HOST_WIDTH];
         default: tx_data_o = rdata_q[`TILE_HOST_WIDTH-1:0];
      endcase
   end

endmodule

`default_nettype wire

// File: source/axi_if.sv
// Single-beat AXI channels between the Wishbone bridge and the RAM model
`timescale 1ns/1ps
`default_nettype none

`include "tile_macros.svh"

interface axi_if;

   // Write address and data
   logic                           aw_valid;
   logic                           aw_ready;
   logic [`TILE_ADDR_WIDTH-1:0]    aw_addr;
   logic                           w_valid;
   logic                           w_ready;
   tile_pkg::data_word_t           w_data;
   logic [`TILE_DATA_WIDTH/8-1:0]  w_strb;

   // Write response
   logic                           b_valid;
   logic                           b_ready;
   tile_pkg::axi_resp_e            b_resp;

   // Read address and data
   logic                           ar_valid;
   logic                           ar_ready;
   logic [`TILE_ADDR_WIDTH-1:0]    ar_addr;
   logic                           r_valid;
   logic                           r_ready;
   tile_pkg::data_word_t           r_data;
   tile_pkg::axi_resp_e            r_resp;

   modport master (
      output aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
      output ar_valid, ar_addr, r_ready,
      input  aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_data, r_resp
   );

   modport slave (
      input  aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
      input  ar_valid, ar_addr, r_ready,
      output aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_data, r_resp
   );

endinterface

`default_nettype wire

// File: source/wb_if.sv
// Wishbone classic bus between the command controller and the AXI bridge
`timescale 1ns/1ps
`default_nettype none

`include "tile_macros.svh"

interface wb_if;

   logic                           cyc;
   logic                           stb;
   logic                           we;
   logic [`TILE_ADDR_WIDTH-1:0]    adr;
   tile_pkg::data_word_t           dat_w;
   logic [`TILE_DATA_WIDTH/8-1:0]  sel;

   // Cycle termination and read data from the slave
   logic                           ack;
   logic                           err;
   tile_pkg::data_word_t           dat_r;

   modport master (
      output cyc, stb, we, adr, dat_w, sel,
      input  ack, err, dat_r
   );

   modport slave (
      input  cyc, stb, we, adr, dat_w, sel,
      output ack, err, dat_r
   );

endinterface

`default_nettype wire

// File: source/tile_pkg.sv
// Host command, response and bus types shared by the tile memory path and its testbench
`default_nettype none

`include "tile_macros.svh"

package tile_pkg;

   // Command opcodes, 0 and 3 are rejected by the controller
   typedef enum logic [1:0] {
      OP_READ  = 2'd1,
      OP_WRITE = 2'd2
   } host_op_e;

   // First word of every command
   typedef struct packed {
      host_op_e    opcode;
      logic [3:0]  byte_sel;
      logic [9:0]  reserved;
   } host_hdr_t;

   typedef union packed {
      host_hdr_t                   hdr;
      logic [`TILE_HOST_WIDTH-1:0] raw;
   } host_word_u;

   typedef enum logic [`TILE_HOST_WIDTH-1:0] {
      ST_OK      = 16'd0,
      ST_BUS_ERR = 16'd1,
      ST_BAD_OP  = 16'd2
   } resp_status_e;

   // AXI response codes used on b and r
   typedef enum logic [1:0] {
      AXI_OKAY   = 2'b00,
      AXI_SLVERR = 2'b10
   } axi_resp_e;

   typedef logic [`TILE_DATA_WIDTH-1:0] data_word_t;

endpackage

`default_nettype wire

// File: source/tile_macros.svh
// Bus widths and buffer depths for the tile memory path, included by RTL and testbench
`ifndef TILE_MACROS_SVH
`define TILE_MACROS_SVH

// Byte address, bus data and host link widths
`define TILE_ADDR_WIDTH 28
`define TILE_DATA_WIDTH 32
`define TILE_HOST_WIDTH 16

// RAM depth in bus words and response FIFO depth
`define TILE_MEM_WORDS 1024
`define TILE_RESP_DEPTH 8

`endif
